/* rtl/game_pkg.sv */
package game_pkg;

    // level code: 0 is the menu, 1 to 5 pick a stage
    typedef logic [2:0] level_t;

    localparam level_t LEVEL_MENU = 3'd0;   // game_state value while the menu is shown
    localparam level_t LEVEL_MIN  = 3'd1;   // lowest selectable stage
    localparam level_t LEVEL_MAX  = 3'd5;   // highest selectable stage

    // pose codes double as sprite indices in the image memory of the full game
    typedef enum logic [3:0] {
        POSE_LEFT   = 4'd2,
        POSE_STATIC = 4'd6,
        POSE_RIGHT  = 4'd7,
        POSE_UP     = 4'd8
    } pose_t;

    // jump phase, idle means standing on ground
    typedef enum logic [1:0] {
        JUMP_IDLE = 2'd0,
        JUMP_RISE = 2'd1,
        JUMP_FALL = 2'd2
    } jump_phase_t;

    // jump timing in clk cycles, scaled way down from the board values
    localparam int JUMP_RISE_CYCLES  = 8;    // counter value where the rise ends
    localparam int JUMP_TOTAL_CYCLES = 16;   // counter value where the jump is spent
    localparam int JUMP_CNT_W        = $clog2(JUMP_TOTAL_CYCLES + 1);

    // one player's direction keys, all active high key-down levels
    typedef struct packed {
        logic up;
        logic left;
        logic down;
        logic right;
    } pad_keys_t;

    // full decoded key vector seen by the core
    typedef struct packed {
        logic      enter;    // launches the selected level from the menu
        pad_keys_t arrows;   // player 1 pad
        pad_keys_t wasd;     // player 2 pad
    } key_set_t;

    // registered player state as handed to the renderer
    typedef struct packed {
        pose_t       pose;
        jump_phase_t phase;
    } player_out_t;

endpackage

/* rtl/level_select.sv */
`timescale 1ns/1ps

module level_select (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::key_set_t keys,
    output game_pkg::level_t   game_state,
    output game_pkg::level_t   selected_level,
    output logic               play_en
);
    import game_pkg::*;

    logic armed;       // press lock, drops after a step and re-arms on all keys up
    logic step_up;     // W or up arrow
    logic step_down;   // S or down arrow
    logic any_key;

    // both pads can drive the menu
    assign step_up   = keys.arrows.up | keys.wasd.up;
    assign step_down = keys.arrows.down | keys.wasd.down;
    assign any_key   = |keys;   // includes enter

    // players only move once a level is running
    assign play_en = (game_state != LEVEL_MENU);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state     <= LEVEL_MENU;
            selected_level <= LEVEL_MIN;
            armed          <= 1'b1;
        end else if (game_state == LEVEL_MENU) begin
            if (!any_key) begin
                armed <= 1'b1;   // key released, next press counts again
            end else if (armed) begin
                // up wins over down, and both win over enter
                if (step_up) begin
                    if (selected_level < LEVEL_MAX) begin
                        selected_level <= selected_level + 3'd1;
                    end
                    armed <= 1'b0;   // one step per press
                end else if (step_down) begin
                    if (selected_level > LEVEL_MIN) begin
                        selected_level <= selected_level - 3'd1;
                    end
                    armed <= 1'b0;
                end else if (keys.enter) begin
                    game_state <= selected_level;   // leaves the menu for good
                end
            end
        end else begin
            // in a level the menu is dead until reset
            armed <= 1'b1;
        end
    end

endmodule

/* rtl/player_ctrl.sv */
`timescale 1ns/1ps

module player_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  play_en,
    input  game_pkg::pad_keys_t   pad,
    input  logic                  collide,
    output game_pkg::player_out_t state
);
    import game_pkg::*;

    logic [JUMP_CNT_W-1:0] jump_cnt;     // cycles spent in the current jump
    logic [JUMP_CNT_W-1:0] cnt_nxt;
    logic [JUMP_CNT_W-1:0] step_cnt;     // counter after one jump step
    jump_phase_t           step_phase;   // phase after one jump step
    player_out_t           state_nxt;

    logic jumping;    // rise or fall in progress
    logic spent;      // counter has run to the end of a jump
    logic no_key;
    logic up_only;
    logic go_left;
    logic go_right;

    assign jumping = (state.phase != JUMP_IDLE);
    assign spent   = (jump_cnt >= JUMP_CNT_W'(JUMP_TOTAL_CYCLES));

    // key cases, checked in this order below
    assign no_key   = !(pad.up | pad.left | pad.down | pad.right);
    assign up_only  = pad.up & !pad.left & !pad.down & !pad.right;
    assign go_left  = (pad.left | pad.up) & !pad.right;
    assign go_right = (pad.right | pad.up) & !pad.left;

    // one jump step, shared by every key case that advances a jump
    always_comb begin
        if (jump_cnt < JUMP_CNT_W'(JUMP_RISE_CYCLES) && !collide
            && state.phase != JUMP_FALL) begin
            step_phase = JUMP_RISE;
            step_cnt   = jump_cnt + 1'b1;
        end else if (jump_cnt < JUMP_CNT_W'(JUMP_TOTAL_CYCLES)) begin
            // a collision ends the rise early, and there is no way back up
            step_phase = JUMP_FALL;
            step_cnt   = jump_cnt + 1'b1;
        end else begin
            step_phase = JUMP_IDLE;   // landed
            step_cnt   = jump_cnt;
        end
    end

    always_comb begin
        state_nxt = state;   // pose and phase hold unless a case below moves them
        cnt_nxt   = jump_cnt;

        if (no_key) begin
            if (!jumping) begin
                state_nxt.pose = POSE_STATIC;
                cnt_nxt        = '0;
            end else begin
                // a jump in the air finishes on its own
                state_nxt.phase = step_phase;
                cnt_nxt         = step_cnt;
            end
        end else if (up_only) begin
            state_nxt.pose  = POSE_UP;
            state_nxt.phase = step_phase;
            cnt_nxt         = spent ? '0 : step_cnt;   // held up starts a fresh jump
        end else if (go_left || go_right) begin
            // left has priority, which also covers up together with down
            state_nxt.pose = go_left ? POSE_LEFT : POSE_RIGHT;
            if (pad.up || jumping) begin
                state_nxt.phase = step_phase;
                cnt_nxt         = spent ? '0 : step_cnt;
            end else begin
                state_nxt.phase = JUMP_IDLE;
                cnt_nxt         = spent ? '0 : jump_cnt;
            end
        end else if (jumping) begin
            // left and right together, or down alone
            state_nxt.phase = step_phase;
            cnt_nxt         = step_cnt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= '{pose: POSE_STATIC, phase: JUMP_IDLE};
            jump_cnt <= '0;
        end else if (play_en) begin   // frozen while the menu is up
            state    <= state_nxt;
            jump_cnt <= cnt_nxt;
        end
    end

endmodule

/* rtl/game_core.sv */
`timescale 1ns/1ps

module game_core (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::key_set_t    keys,
    input  logic                  p1_collide,
    input  logic                  p2_collide,
    output game_pkg::level_t      game_state,
    output game_pkg::level_t      selected_level,
    output game_pkg::player_out_t p1,
    output game_pkg::player_out_t p2
);
    import game_pkg::*;

    logic      play_en;   // high once a level has been launched
    pad_keys_t p1_pad;    // arrow keys
    pad_keys_t p2_pad;    // W A S D

    assign p1_pad = keys.arrows;
    assign p2_pad = keys.wasd;

    level_select u_level_select (
        .clk            (clk),
        .rst            (rst),
        .keys           (keys),
        .game_state     (game_state),
        .selected_level (selected_level),
        .play_en        (play_en)
    );

    player_ctrl u_player1 (
        .clk     (clk),
        .rst     (rst),
        .play_en (play_en),
        .pad     (p1_pad),
        .collide (p1_collide),
        .state   (p1)
    );

    player_ctrl u_player2 (
        .clk     (clk),
        .rst     (rst),
        .play_en (play_en),
        .pad     (p2_pad),
        .collide (p2_collide),
        .state   (p2)
    );

endmodule

/* tb/game_core_assert.sv */
`timescale 1ns/1ps

module game_core_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  play_en,
    input game_pkg::level_t      game_state,
    input game_pkg::level_t      selected_level,
    input game_pkg::player_out_t p1,
    input game_pkg::player_out_t p2
);
    import game_pkg::*;

    int unsigned fail_cnt = 0;   // number of property failures so far

    // selection saturates and never wraps into the menu code
    a_level_range: assert property (@(posedge clk) disable iff (rst)
        selected_level >= LEVEL_MIN && selected_level <= LEVEL_MAX)
        else begin
            fail_cnt++;
            $error("selected_level outside 1 to 5");
        end

    // once falling a player only lands, never rises again
    a_p1_no_rerise: assert property (@(posedge clk) disable iff (rst)
        p1.phase == JUMP_FALL |=> p1.phase != JUMP_RISE)
        else begin
            fail_cnt++;
            $error("p1 went from fall back to rise");
        end

    a_p2_no_rerise: assert property (@(posedge clk) disable iff (rst)
        p2.phase == JUMP_FALL |=> p2.phase != JUMP_RISE)
        else begin
            fail_cnt++;
            $error("p2 went from fall back to rise");
        end

    a_state_locked: assert property (@(posedge clk) disable iff (rst)
        game_state != LEVEL_MENU |=> $stable(game_state))   // a launched level stays
        else begin
            fail_cnt++;
            $error("game_state changed after launch");
        end

    // players are frozen by the enable seen at the same edge
    a_frozen: assert property (@(posedge clk) disable iff (rst)
        !play_en |=> $stable(p1) && $stable(p2))
        else begin
            fail_cnt++;
            $error("player outputs moved while play was disabled");
        end

endmodule

bind game_core game_core_assert u_game_core_assert (
    .clk            (clk),
    .rst            (rst),
    .play_en        (play_en),
    .game_state     (game_state),
    .selected_level (selected_level),
    .p1             (p1),
    .p2             (p2)
);

/* tb/tb_game_core.sv */
`timescale 1ns/1ps

module tb_game_core;
    import game_pkg::*;

    localparam int TIMEOUT_CYCLES = 64;   // far longer than any jump

    logic        clk;
    logic        rst;
    key_set_t    keys;
    logic        p1_collide;
    logic        p2_collide;
    level_t      game_state;
    level_t      selected_level;
    player_out_t p1;
    player_out_t p2;

    level_t exp_level;   // expected menu selection, kept by the stepping rules

    game_core UUT (
        .clk            (clk),
        .rst            (rst),
        .keys           (keys),
        .p1_collide     (p1_collide),
        .p2_collide     (p2_collide),
        .game_state     (game_state),
        .selected_level (selected_level),
        .p1             (p1),
        .p2             (p2)
    );

    always #2 clk = ~clk;   // 4 ns period

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        if (UUT.u_game_core_assert.fail_cnt != 0) begin
            $display("a concurrent assertion on game_core failed");
            stop_with_failure();
        end
    end

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // inputs change and outputs are read 1 ns after the rising edge
    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    function automatic player_out_t player_state(input int who);
        return (who == 1) ? p1 : p2;
    endfunction

    task automatic check_player(input int who, input pose_t pose, input jump_phase_t phase);
        player_out_t cur;
        string       tag;
        cur = player_state(who);
        tag = (who == 1) ? "p1" : "p2";
        check_value({tag, ".pose"}, 8'(cur.pose), 8'(pose));
        check_value({tag, ".phase"}, 8'(cur.phase), 8'(phase));
    endtask

    // counts the samples that show one phase, starting with the current one
    task automatic count_phase(input int who, input jump_phase_t phase, input bit mirror,
                               output int n);
        player_out_t cur;
        n   = 0;
        cur = player_state(who);
        while (cur.phase == phase) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                $display("player %0d stayed in one jump phase for too long", who);
                stop_with_failure();
            end
            if (mirror) begin
                check_player(3 - who, POSE_UP, phase);   // both pads pressed alike
            end
            step_clock();
            cur = player_state(who);
        end
    endtask

    // one separated menu press on either pad, then a release gap
    task automatic menu_press(input bit up, input bit use_wasd, input int hold);
        pad_keys_t pad;
        int        gap;
        pad      = '0;
        pad.up   = up;
        pad.down = !up;
        gap      = int'($urandom_range(1, 3));
        if (use_wasd) begin
            keys.wasd = pad;
        end else begin
            keys.arrows = pad;
        end
        if (up && exp_level < LEVEL_MAX) begin
            exp_level = exp_level + 3'd1;
        end else if (!up && exp_level > LEVEL_MIN) begin
            exp_level = exp_level - 3'd1;
        end
        repeat (hold) begin
            step_clock();   // only the first edge of the press may step
            check_value("selected_level", 8'(selected_level), 8'(exp_level));
            check_value("game_state", 8'(game_state), 8'(LEVEL_MENU));
        end
        keys = '0;
        repeat (gap) begin
            step_clock();
            check_value("selected_level", 8'(selected_level), 8'(exp_level));
        end
    endtask

    // both players jump together while up stays held
    task automatic full_jump();
        int n;
        keys.arrows.up = 1'b1;
        keys.wasd.up   = 1'b1;
        step_clock();
        check_player(1, POSE_UP, JUMP_RISE);
        check_player(2, POSE_UP, JUMP_RISE);
        count_phase(1, JUMP_RISE, 1'b1, n);
        check_value("p1 rise edge count", 8'(n), 8'(JUMP_RISE_CYCLES));
        check_player(1, POSE_UP, JUMP_FALL);
        check_player(2, POSE_UP, JUMP_FALL);
        count_phase(1, JUMP_FALL, 1'b1, n);
        // counter runs from one past the rise limit up to the total
        check_value("p1 fall edge count", 8'(n), 8'(JUMP_TOTAL_CYCLES - JUMP_RISE_CYCLES));
        check_player(1, POSE_UP, JUMP_IDLE);
        check_player(2, POSE_UP, JUMP_IDLE);
        keys = '0;
        step_clock();
        check_player(1, POSE_STATIC, JUMP_IDLE);
        check_player(2, POSE_STATIC, JUMP_IDLE);
    endtask

    // collision part way up cuts the rise short
    task automatic early_fall(input int who);
        pad_keys_t pad;
        int        rise_n;
        int        n;
        pad    = '0;
        pad.up = 1'b1;
        rise_n = int'($urandom_range(1, JUMP_RISE_CYCLES - 2));
        if (who == 1) begin
            keys.arrows = pad;
        end else begin
            keys.wasd = pad;
        end
        repeat (rise_n) begin
            step_clock();
            check_player(who, POSE_UP, JUMP_RISE);
        end
        if (who == 1) begin
            p1_collide = 1'b1;
        end else begin
            p2_collide = 1'b1;
        end
        step_clock();
        check_player(who, POSE_UP, JUMP_FALL);
        keys       = '0;   // the jump finishes on its own
        p1_collide = 1'b0;
        p2_collide = 1'b0;
        count_phase(who, JUMP_FALL, 1'b0, n);
        check_value("fall edge count", 8'(n), 8'(JUMP_TOTAL_CYCLES - rise_n));
        check_player(who, POSE_UP, JUMP_IDLE);
        step_clock();
        check_player(1, POSE_STATIC, JUMP_IDLE);
        check_player(2, POSE_STATIC, JUMP_IDLE);
    endtask

    initial begin
        int presses;
        int hold;
        void'($urandom(32'hcce6ee3d));
        clk        = 1'b0;
        rst        = 1'b1;
        keys       = '0;
        p1_collide = 1'b0;
        p2_collide = 1'b0;
        exp_level  = LEVEL_MIN;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("game_state", 8'(game_state), 8'(LEVEL_MENU));
        check_value("selected_level", 8'(selected_level), 8'(LEVEL_MIN));
        check_player(1, POSE_STATIC, JUMP_IDLE);
        check_player(2, POSE_STATIC, JUMP_IDLE);

        // side keys and a collision in the menu must not move anybody
        keys.arrows.left = 1'b1;
        keys.wasd.right  = 1'b1;
        p1_collide       = 1'b1;
        repeat (3) begin
            step_clock();
            check_player(1, POSE_STATIC, JUMP_IDLE);
            check_player(2, POSE_STATIC, JUMP_IDLE);
            check_value("selected_level", 8'(selected_level), 8'(LEVEL_MIN));
        end
        keys       = '0;
        p1_collide = 1'b0;
        step_clock();

        presses = int'($urandom_range(4, 10));
        repeat (presses) begin
            menu_press(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                       int'($urandom_range(1, 4)));
        end
        repeat (LEVEL_MAX) menu_press(1'b1, 1'b0, 1);   // runs into the top limit
        menu_press(1'b0, 1'b1, 20);                      // long hold steps once
        repeat (LEVEL_MAX) menu_press(1'b0, 1'b0, 2);   // runs into the bottom limit
        repeat (int'($urandom_range(1, 4))) menu_press(1'b1, 1'($urandom_range(0, 1)), 1);

        check_value("game_state", 8'(game_state), 8'(LEVEL_MENU));
        keys.enter = 1'b1;
        step_clock();
        check_value("game_state", 8'(game_state), 8'(exp_level));

        // enter and down keep coming but the menu is closed now
        keys.wasd.down   = 1'b1;
        keys.arrows.down = 1'b1;
        hold = int'($urandom_range(2, 6));
        repeat (hold) begin
            step_clock();
            check_value("game_state", 8'(game_state), 8'(exp_level));
            check_value("selected_level", 8'(selected_level), 8'(exp_level));
            check_player(1, POSE_STATIC, JUMP_IDLE);
            check_player(2, POSE_STATIC, JUMP_IDLE);
        end
        keys = '0;
        step_clock();

        full_jump();
        early_fall(1);
        early_fall(2);

        keys.arrows.left = 1'b1;
        keys.wasd.right  = 1'b1;
        step_clock();
        check_player(1, POSE_LEFT, JUMP_IDLE);
        check_player(2, POSE_RIGHT, JUMP_IDLE);
        keys              = '0;
        keys.arrows.right = 1'b1;
        keys.wasd.left    = 1'b1;
        step_clock();
        check_player(1, POSE_RIGHT, JUMP_IDLE);
        check_player(2, POSE_LEFT, JUMP_IDLE);
        keys = '0;
        step_clock();
        check_player(1, POSE_STATIC, JUMP_IDLE);
        check_player(2, POSE_STATIC, JUMP_IDLE);

        if (UUT.u_game_core_assert.fail_cnt == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d concurrent assertions failed", UUT.u_game_core_assert.fail_cnt);
            stop_with_failure();
        end
    end

endmodule

/* src.f */
rtl/game_pkg.sv
rtl/level_select.sv
rtl/player_ctrl.sv
rtl/game_core.sv
tb/game_core_assert.sv
tb/tb_game_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_game_core
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
